// File: flist.f
hw/adam_input_pkg.sv
hw/clk_en_gen.sv
hw/ps2_keypad_emu.sv
hw/ctrl_port_mux.sv
hw/adam_input_top.sv
verif/tb_clk_gen.sv
verif/adam_input_tb.sv

// File: hw/adam_input_pkg.sv
/*
 * Controller input package
 * Widths, bit positions, keypad codes, PS/2 scancodes and the packed
 * types shared by the controller-input path of the computer core
 */
package adam_input_pkg;

        // ==============================
        // Widths and counts
        // ==============================
        localparam int JOY_W       = 32;
        localparam int KV_W        = 20;
        localparam int KV_NUM_KEYS = 14;
        localparam int NUM_DIGITS  = 10;
        localparam int NUM_PLAYERS = 2;

        // Divider for the 10.7 MHz and 5.3 MHz strobes
        localparam int CE_DIV_W = 3;
        localparam logic [1:0] CE_FAST_MASK = 2'b11;

        // Bit positions in the host joystick word
        localparam int JOY_RIGHT  = 0;
        localparam int JOY_LEFT   = 1;
        localparam int JOY_DOWN   = 2;
        localparam int JOY_UP     = 3;
        localparam int JOY_FIRE1  = 4;
        localparam int JOY_FIRE2  = 5;
        localparam int JOY_STAR   = 6;
        localparam int JOY_HASH   = 7;
        localparam int JOY_DIGIT0 = 8;
        localparam int JOY_PURPLE = 18;
        localparam int JOY_BLUE   = 19;

        // Positions in the remapped key vector, digits sit at 0..9
        localparam int KV_STAR   = 10;
        localparam int KV_HASH   = 11;
        localparam int KV_PURPLE = 12;
        localparam int KV_BLUE   = 13;
        localparam int KV_UP     = 14;
        localparam int KV_DOWN   = 15;
        localparam int KV_LEFT   = 16;
        localparam int KV_RIGHT  = 17;
        localparam int KV_FIRE1  = 18;
        localparam int KV_FIRE2  = 19;

        // ==============================
        // Keypad codes on the data lines
        // ==============================
        localparam logic [3:0] KEY_CODE_0      = 4'b0011;
        localparam logic [3:0] KEY_CODE_1      = 4'b1110;
        localparam logic [3:0] KEY_CODE_2      = 4'b1101;
        localparam logic [3:0] KEY_CODE_3      = 4'b0110;
        localparam logic [3:0] KEY_CODE_4      = 4'b0001;
        localparam logic [3:0] KEY_CODE_5      = 4'b1001;
        localparam logic [3:0] KEY_CODE_6      = 4'b0111;
        localparam logic [3:0] KEY_CODE_7      = 4'b1100;
        localparam logic [3:0] KEY_CODE_8      = 4'b1000;
        localparam logic [3:0] KEY_CODE_9      = 4'b1011;
        localparam logic [3:0] KEY_CODE_STAR   = 4'b1010;
        localparam logic [3:0] KEY_CODE_HASH   = 4'b0101;
        localparam logic [3:0] KEY_CODE_PURPLE = 4'b0100;
        localparam logic [3:0] KEY_CODE_BLUE   = 4'b0010;
        localparam logic [3:0] KEY_CODE_NONE   = 4'b1111;

        // Indexed like the key vector, index 0 has top priority
        localparam logic [3:0] KEY_CODE_TBL [KV_NUM_KEYS] = '{
                KEY_CODE_0, KEY_CODE_1, KEY_CODE_2, KEY_CODE_3, KEY_CODE_4,
                KEY_CODE_5, KEY_CODE_6, KEY_CODE_7, KEY_CODE_8, KEY_CODE_9,
                KEY_CODE_STAR, KEY_CODE_HASH, KEY_CODE_PURPLE, KEY_CODE_BLUE
        };

        // PS/2 set 2 scancodes, digit tables indexed by digit value
        localparam logic [7:0] SC_DIGIT_MAIN [NUM_DIGITS] = '{
                8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
        };
        localparam logic [7:0] SC_DIGIT_PAD [NUM_DIGITS] = '{
                8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B, 8'h73, 8'h74, 8'h6C, 8'h75, 8'h7D
        };
        localparam logic [7:0] SC_KP_STAR  = 8'h7C;
        localparam logic [7:0] SC_KP_MINUS = 8'h7B;
        localparam logic [7:0] SC_SHIFT_L  = 8'h12;
        localparam logic [7:0] SC_SHIFT_R  = 8'h59;

        // ==============================
        // Types
        // ==============================
        typedef logic [JOY_W-1:0] joy_word_t;
        typedef logic [KV_W-1:0]  keypad_vec_t;
        typedef logic [KV_W-1:0]  emu_keys_t;

        typedef struct packed {
                logic keypad_sel_n;
                logic joy_sel_n;
        } ctrl_sel_t;

        typedef struct packed {
                logic [3:0] data;
                logic       fire_n;
        } ctrl_port_t;

        typedef struct packed {
                logic       toggle;
                logic       pressed;
                logic       ext;
                logic [7:0] code;
        } ps2_event_t;

endpackage

// File: hw/adam_input_top.sv
/*
 * Controller input top level
 * Builds the system reset request, swaps the players and connects
 * the strobe divider, keypad emulation and both port encoders
 */
`timescale 1ns/1ps

module adam_input_top (
        input  logic                       clk_sys,
        input  logic                       rst_n_i,
        input  logic                       osd_reset_i,
        input  logic                       user_button_i,
        input  logic                       console_mode_i,
        input  logic                       swap_i,
        input  adam_input_pkg::joy_word_t  joy0_i,
        input  adam_input_pkg::joy_word_t  joy1_i,
        input  adam_input_pkg::ps2_event_t ps2_evt_i,
        input  adam_input_pkg::ctrl_sel_t  sel0_i,
        input  adam_input_pkg::ctrl_sel_t  sel1_i,
        output adam_input_pkg::ctrl_port_t port0_o,
        output adam_input_pkg::ctrl_port_t port1_o,
        output logic                       ce_fast_o,
        output logic                       ce_pix_o,
        output logic                       sys_rst_n_o
);
        import adam_input_pkg::*;

        logic       mode_q;
        logic       mode_chg_q;
        emu_keys_t  emu_keys;
        joy_word_t  joy_pl  [NUM_PLAYERS];
        ctrl_sel_t  sel_pl  [NUM_PLAYERS];
        ctrl_port_t port_pl [NUM_PLAYERS];

        // ==============================
        // Reset request
        // ==============================
        // Mode copy tracks during reset too, only a real switch pulses
        always_ff @(posedge clk_sys) begin
                mode_q <= console_mode_i;
                if (!rst_n_i) begin
                        mode_chg_q <= 1'b0;
                end else begin
                        mode_chg_q <= console_mode_i != mode_q;
                end
        end

        assign sys_rst_n_o = rst_n_i & ~osd_reset_i & ~user_button_i & ~mode_chg_q;

        // Console/computer switch restarts the machine
        a_mode_reset: assert property (
                @(posedge clk_sys) disable iff (!rst_n_i)
                (console_mode_i != $past(console_mode_i)) |=> !sys_rst_n_o
        ) else $error("mode change did not request a reset");

        // ==============================
        // Player routing
        // ==============================
        assign joy_pl[0] = swap_i ? joy1_i : joy0_i;
        assign joy_pl[1] = swap_i ? joy0_i : joy1_i;
        assign sel_pl[0] = sel0_i;
        assign sel_pl[1] = sel1_i;
        assign port0_o   = port_pl[0];
        assign port1_o   = port_pl[1];

        clk_en_gen clk_en_gen_i (
                .clk_sys   (clk_sys),
                .rst_n_i   (rst_n_i),
                .ce_fast_o (ce_fast_o),
                .ce_pix_o  (ce_pix_o)
        );

        ps2_keypad_emu ps2_keypad_emu_i (
                .clk_sys    (clk_sys),
                .rst_n_i    (rst_n_i),
                .ps2_evt_i  (ps2_evt_i),
                .emu_keys_o (emu_keys)
        );

        // Keyboard keys reach both ports
        for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_port
                ctrl_port_mux ctrl_port_mux_i (
                        .sel_i      (sel_pl[p]),
                        .joy_i      (joy_pl[p]),
                        .emu_keys_i (emu_keys),
                        .port_o     (port_pl[p])
                );
        end

endmodule

// File: hw/clk_en_gen.sv
/*
 * Clock-enable divider
 * Free-running counter giving a 1-in-4 fast strobe and a 1-in-8 pixel
 * strobe, the pixel strobe always coinciding with a fast one
 */
`timescale 1ns/1ps

module clk_en_gen (
        input  logic clk_sys,
        input  logic rst_n_i,
        output logic ce_fast_o,
        output logic ce_pix_o
);
        import adam_input_pkg::*;

        logic [CE_DIV_W-1:0] div_q;

        // Strobes are registered from the counter zero states
        always_ff @(posedge clk_sys) begin
                if (!rst_n_i) begin
                        div_q     <= '0;
                        ce_fast_o <= 1'b0;
                        ce_pix_o  <= 1'b0;
                end else begin
                        div_q     <= div_q + CE_DIV_W'(1);
                        ce_fast_o <= (div_q[1:0] & CE_FAST_MASK) == '0;
                        ce_pix_o  <= div_q == '0;
                end
        end

        // Downstream logic running on ce_pix expects a fast tick in the same cycle
        a_pix_on_fast: assert property (
                @(posedge clk_sys) disable iff (!rst_n_i)
                ce_pix_o |-> ce_fast_o
        ) else $error("ce_pix_o high without ce_fast_o");

endmodule

// File: hw/ctrl_port_mux.sv
/*
 * Controller port encoder
 * Remaps one player's joystick word, merges the emulated keys and
 * drives the data and fire lines for the console's select signals
 */
`timescale 1ns/1ps

module ctrl_port_mux (
        input  adam_input_pkg::ctrl_sel_t  sel_i,
        input  adam_input_pkg::joy_word_t  joy_i,
        input  adam_input_pkg::emu_keys_t  emu_keys_i,
        output adam_input_pkg::ctrl_port_t port_o
);
        import adam_input_pkg::*;

        keypad_vec_t joy_vec;
        keypad_vec_t keys;
        logic [3:0]  kp_code;
        logic [3:0]  kp_data;
        logic [3:0]  js_data;
        logic        kp_fire_n;
        logic        js_fire_n;

        // ==============================
        // Remap into keypad order
        // ==============================
        always_comb begin
                for (int i = 0; i < NUM_DIGITS; i++) begin
                        joy_vec[i] = joy_i[JOY_DIGIT0 + i];
                end
                joy_vec[KV_STAR]   = joy_i[JOY_STAR];
                joy_vec[KV_HASH]   = joy_i[JOY_HASH];
                joy_vec[KV_PURPLE] = joy_i[JOY_PURPLE];
                joy_vec[KV_BLUE]   = joy_i[JOY_BLUE];
                joy_vec[KV_UP]     = joy_i[JOY_UP];
                joy_vec[KV_DOWN]   = joy_i[JOY_DOWN];
                joy_vec[KV_LEFT]   = joy_i[JOY_LEFT];
                joy_vec[KV_RIGHT]  = joy_i[JOY_RIGHT];
                joy_vec[KV_FIRE1]  = joy_i[JOY_FIRE1];
                joy_vec[KV_FIRE2]  = joy_i[JOY_FIRE2];
        end

        // Keyboard presses count as if the pad button were held
        assign keys = joy_vec | emu_keys_i;

        // ==============================
        // Keypad term
        // ==============================
        // Scan from the top so the lowest pressed index wins
        always_comb begin
                kp_code = KEY_CODE_NONE;
                for (int i = KV_NUM_KEYS - 1; i >= 0; i--) begin
                        if (keys[i]) begin
                                kp_code = KEY_CODE_TBL[i];
                        end
                end
        end

        assign kp_data   = sel_i.keypad_sel_n ? KEY_CODE_NONE : kp_code;
        // fire 2 shows up on the keypad scan
        assign kp_fire_n = sel_i.keypad_sel_n | ~keys[KV_FIRE2];

        // ==============================
        // Joystick term
        // ==============================
        assign js_data   = sel_i.joy_sel_n ? 4'b1111 :
                           ~{keys[KV_UP], keys[KV_DOWN], keys[KV_LEFT], keys[KV_RIGHT]};
        assign js_fire_n = sel_i.joy_sel_n | ~keys[KV_FIRE1];

        // Lines are open-drain on the real port, so both terms wire-AND
        assign port_o.data   = kp_data & js_data;
        assign port_o.fire_n = kp_fire_n & js_fire_n;

        // Idle port must read as released, the BIOS polls it that way
        always_comb begin
                if (sel_i.keypad_sel_n && sel_i.joy_sel_n) begin
                        a_idle_port: assert final (port_o.data == KEY_CODE_NONE &&
                                                   port_o.fire_n)
                        else $error("port not idle with both selects inactive");
                end
        end

endmodule

// File: hw/ps2_keypad_emu.sv
/*
 * PS/2 keypad emulation
 * Follows make and break events from the keyboard and holds the
 * state of the emulated keypad buttons, digits plus star and hash
 */
`timescale 1ns/1ps

module ps2_keypad_emu (
        input  logic                       clk_sys,
        input  logic                       rst_n_i,
        input  adam_input_pkg::ps2_event_t ps2_evt_i,
        output adam_input_pkg::emu_keys_t  emu_keys_o
);
        import adam_input_pkg::*;

        logic                  toggle_q;
        logic                  new_evt;
        logic [NUM_DIGITS-1:0] btn_digit_q;
        logic                  btn_star_q;
        logic                  btn_minus_q;
        logic                  btn_shift_q;

        // A flip of the toggle bit marks one new event
        assign new_evt = ps2_evt_i.toggle != toggle_q;

        // ==============================
        // Button registers
        // ==============================
        // Toggle copy follows the input even in reset, so no event fires on release
        always_ff @(posedge clk_sys) begin
                toggle_q <= ps2_evt_i.toggle;
                if (!rst_n_i) begin
                        btn_digit_q <= '0;
                        btn_star_q  <= 1'b0;
                        btn_minus_q <= 1'b0;
                        btn_shift_q <= 1'b0;
                end else if (new_evt) begin
                        // Main row and numeric pad drive the same digit
                        for (int i = 0; i < NUM_DIGITS; i++) begin
                                if (ps2_evt_i.code == SC_DIGIT_MAIN[i] ||
                                    ps2_evt_i.code == SC_DIGIT_PAD[i]) begin
                                        btn_digit_q[i] <= ps2_evt_i.pressed;
                                end
                        end
                        // E0 prefix not decoded, cursor keys alias onto the pad
                        case (ps2_evt_i.code)
                                SC_KP_STAR: begin
                                        btn_star_q <= ps2_evt_i.pressed;
                                end
                                SC_KP_MINUS: begin
                                        btn_minus_q <= ps2_evt_i.pressed;
                                end
                                SC_SHIFT_L, SC_SHIFT_R: begin
                                        btn_shift_q <= ps2_evt_i.pressed;
                                end
                                default: begin
                                end
                        endcase
                end
        end

        // ==============================
        // Key vector
        // ==============================
        // Shift+8 gives star and shift+3 gives hash, as printed on a PC keyboard
        always_comb begin
                emu_keys_o                       = '0;
                emu_keys_o[NUM_DIGITS-1:0]       = btn_digit_q;
                emu_keys_o[KV_STAR]              = btn_star_q | (btn_shift_q & btn_digit_q[8]);
                emu_keys_o[KV_HASH]              = btn_minus_q | (btn_shift_q & btn_digit_q[3]);
        end

        // Keys may only move on the cycle after an event or after a reset
        a_keys_need_event: assert property (
                @(posedge clk_sys) disable iff (!rst_n_i)
                !$stable(emu_keys_o) |-> ($past(new_evt) || !$past(rst_n_i))
        ) else $error("emulated keys changed without a PS/2 event");

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the controller-input testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
        --top-module adam_input_tb \
        -Mdir obj_dir \
        -o adam_input_sim \
        -f flist.f

# The simulator may exit non-zero on failure; the pass message decides
out=$(./obj_dir/adam_input_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^Test passed$"; then
        exit 0
else
        exit 1
fi

// File: verif/adam_input_tb.sv
/*
 * Controller input testbench
 * Drives the strobe divider, keypad and joystick encoding, player swap,
 * PS/2 keypad emulation and reset request, checked by assertions
 */
`timescale 1ns/1ps

module adam_input_tb;
        import adam_input_pkg::*;

        localparam int N_VEC          = 450;
        localparam int STROBE_CYCLES  = 64;
        // Reset, strobe test, three random tests, PS/2 and reset tests, then doubled
        localparam int TIMEOUT_CYCLES = 2 * (10 + 4 + STROBE_CYCLES + 3 * N_VEC + 60);

        logic       clk_sys;
        logic       rst_n;
        logic       osd_reset;
        logic       user_button;
        logic       console_mode;
        logic       swap;
        joy_word_t  joy0;
        joy_word_t  joy1;
        ps2_event_t ps2_evt;
        ctrl_sel_t  sel0;
        ctrl_sel_t  sel1;
        ctrl_port_t port0;
        ctrl_port_t port1;
        logic       ce_fast;
        logic       ce_pix;
        logic       sys_rst_n;

        integer     seed;
        int         cycle_cnt    = 0;
        int         test_errs    = 0;
        int         total_errs   = 0;
        int         tests_run    = 0;
        int         tests_failed = 0;
        string      test_name;

        tb_clk_gen tb_clk_gen_i (
                .clk_sys (clk_sys),
                .rst_n_o (rst_n)
        );

        adam_input_top adam_input_top_i (
                .clk_sys        (clk_sys),
                .rst_n_i        (rst_n),
                .osd_reset_i    (osd_reset),
                .user_button_i  (user_button),
                .console_mode_i (console_mode),
                .swap_i         (swap),
                .joy0_i         (joy0),
                .joy1_i         (joy1),
                .ps2_evt_i      (ps2_evt),
                .sel0_i         (sel0),
                .sel1_i         (sel1),
                .port0_o        (port0),
                .port1_o        (port1),
                .ce_fast_o      (ce_fast),
                .ce_pix_o       (ce_pix),
                .sys_rst_n_o    (sys_rst_n)
        );

        // ==============================
        // Reference rules
        // ==============================
        function automatic logic [3:0] key_code_of(input int idx);
                case (idx)
                        0:       return KEY_CODE_0;
                        1:       return KEY_CODE_1;
                        2:       return KEY_CODE_2;
                        3:       return KEY_CODE_3;
                        4:       return KEY_CODE_4;
                        5:       return KEY_CODE_5;
                        6:       return KEY_CODE_6;
                        7:       return KEY_CODE_7;
                        8:       return KEY_CODE_8;
                        9:       return KEY_CODE_9;
                        10:      return KEY_CODE_STAR;
                        11:      return KEY_CODE_HASH;
                        12:      return KEY_CODE_PURPLE;
                        13:      return KEY_CODE_BLUE;
                        default: return KEY_CODE_NONE;
                endcase
        endfunction

        // Digits, star, hash, purple, blue; the first one held wins
        function automatic logic [3:0] keypad_ref(input joy_word_t j);
                logic [13:0] held;
                logic [3:0]  code;
                logic        found;
                held  = {j[19], j[18], j[7], j[6], j[17:8]};
                code  = KEY_CODE_NONE;
                found = 1'b0;
                for (int i = 0; i < 14; i++) begin
                        if (held[i] && !found) begin
                                code  = key_code_of(i);
                                found = 1'b1;
                        end
                end
                return code;
        endfunction

        function automatic ctrl_port_t port_ref(input ctrl_sel_t sel, input joy_word_t j);
                ctrl_port_t p;
                logic [3:0] kp_data;
                logic [3:0] js_data;
                kp_data  = sel.keypad_sel_n ? KEY_CODE_NONE : keypad_ref(j);
                // Joystick lines in order up, down, left, right
                js_data  = sel.joy_sel_n ? 4'b1111 : ~{j[3], j[2], j[1], j[0]};
                p.data   = kp_data & js_data;
                p.fire_n = (sel.keypad_sel_n | ~j[5]) & (sel.joy_sel_n | ~j[4]);
                return p;
        endfunction

        // 0 keypad only, 1 joystick only, 2 both, 3 none
        function automatic ctrl_sel_t sel_for(input logic [1:0] m);
                ctrl_sel_t s;
                s.keypad_sel_n = (m == 2'd1) || (m == 2'd3);
                s.joy_sel_n    = (m == 2'd0) || (m == 2'd3);
                return s;
        endfunction

        // ==============================
        // Checks and reporting
        // ==============================
        task automatic check_port(input string what, input ctrl_port_t exp, input ctrl_port_t act);
                assert (act == exp) else begin
                        $display("[ERROR] %s: %s expected data=%b fire_n=%b, actual data=%b fire_n=%b",
                                 test_name, what, exp.data, exp.fire_n, act.data, act.fire_n);
                        test_errs++;
                end
        endtask

        task automatic check_int(input string what, input int exp, input int act);
                assert (act == exp) else begin
                        $display("[ERROR] %s: %s expected %0d, actual %0d",
                                 test_name, what, exp, act);
                        test_errs++;
                end
        endtask

        task automatic check_bit(input string what, input logic exp, input logic act);
                assert (act === exp) else begin
                        $display("[ERROR] %s: %s expected %b, actual %b", test_name, what, exp, act);
                        test_errs++;
                end
        endtask

        task automatic start_test(input string name);
                test_name = name;
                test_errs = 0;
        endtask

        task automatic finish_test();
                tests_run++;
                total_errs += test_errs;
                if (test_errs == 0) begin
                        $display("%s: PASS", test_name);
                end else begin
                        tests_failed++;
                        $display("%s: FAIL with %0d mismatches", test_name, test_errs);
                end
        endtask

        // ==============================
        // Stimulus helpers
        // ==============================
        task automatic drive_random_joys(input int n);
                joy0 = $random(seed);
                joy1 = $random(seed);
                // Thin out every other word so later keys in the order also win
                if (n % 2 == 1) begin
                        joy0 = joy0 & $random(seed) & $random(seed);
                        joy1 = joy1 & $random(seed) & $random(seed);
                end
        endtask

        task automatic send_ps2(input logic [7:0] code, input logic pressed,
                                input logic [3:0] exp_code);
                ctrl_port_t exp;
                @(negedge clk_sys);
                ps2_evt.code    = code;
                ps2_evt.pressed = pressed;
                ps2_evt.ext     = 1'b0;
                ps2_evt.toggle  = ~ps2_evt.toggle;
                exp.data        = exp_code;
                exp.fire_n      = 1'b1;
                @(negedge clk_sys);
                check_port("port0 after PS/2 event", exp, port0);
                check_port("port1 after PS/2 event", exp, port1);
        endtask

        always @(posedge clk_sys) begin
                cycle_cnt++;
                if (cycle_cnt >= TIMEOUT_CYCLES) begin
                        $display("Run stopped at the %0d cycle limit before the tests finished",
                                 TIMEOUT_CYCLES);
                        $display("Test failed");
                        $finish;
                end
        end

        // ==============================
        // Test sequence
        // ==============================
        initial begin
                int          lat;
                int          fast_cnt;
                int          pix_cnt;
                int          low_cnt;
                logic [31:0] rnd;
                seed         = 32'h3e78e70a;
                osd_reset    = 1'b0;
                user_button  = 1'b0;
                console_mode = 1'b0;
                swap         = 1'b0;
                joy0         = '0;
                joy1         = '0;
                ps2_evt      = '0;
                sel0         = sel_for(2'd3);
                sel1         = sel_for(2'd3);

                @(posedge rst_n);

                start_test("strobes");
                lat = 0;
                do begin
                        @(negedge clk_sys);
                        lat++;
                end while (!ce_fast && lat < 8);
                assert (lat <= 4) else begin
                        $display("[ERROR] %s: first ce_fast_o came %0d cycles after reset, over 4",
                                 test_name, lat);
                        test_errs++;
                end
                fast_cnt = 0;
                pix_cnt  = 0;
                for (int i = 0; i < STROBE_CYCLES; i++) begin
                        @(negedge clk_sys);
                        fast_cnt += int'(ce_fast);
                        pix_cnt  += int'(ce_pix);
                        check_bit("ce_fast_o while ce_pix_o high", 1'b1, ce_fast | ~ce_pix);
                end
                check_int("ce_fast_o count", STROBE_CYCLES / 4, fast_cnt);
                check_int("ce_pix_o count", STROBE_CYCLES / 8, pix_cnt);
                finish_test();

                start_test("keypad priority");
                for (int i = 0; i < N_VEC; i++) begin
                        @(negedge clk_sys);
                        drive_random_joys(i);
                        sel0 = sel_for(2'd0);
                        sel1 = sel_for(2'd3);
                        @(posedge clk_sys);
                        check_port("port0", port_ref(sel0, joy0), port0);
                        check_port("idle port1", port_ref(sel1, joy1), port1);
                end
                finish_test();

                start_test("joystick select");
                for (int i = 0; i < N_VEC; i++) begin
                        @(negedge clk_sys);
                        drive_random_joys(i);
                        sel0 = sel_for(2'(1 + i % 3));
                        sel1 = sel_for(2'(1 + (i + 1) % 3));
                        @(posedge clk_sys);
                        check_port("port0", port_ref(sel0, joy0), port0);
                        check_port("port1", port_ref(sel1, joy1), port1);
                end
                finish_test();

                start_test("player swap");
                for (int i = 0; i < N_VEC; i++) begin
                        @(negedge clk_sys);
                        drive_random_joys(i);
                        rnd  = $random(seed);
                        swap = 1'b1;
                        sel0 = sel_for(rnd[1:0]);
                        sel1 = sel_for(rnd[3:2]);
                        @(posedge clk_sys);
                        check_port("port0 from joy1_i", port_ref(sel0, joy1), port0);
                        check_port("port1 from joy0_i", port_ref(sel1, joy0), port1);
                end
                finish_test();

                start_test("PS/2 keypad emulation");
                @(negedge clk_sys);
                swap = 1'b0;
                joy0 = '0;
                joy1 = '0;
                sel0 = sel_for(2'd0);
                sel1 = sel_for(2'd0);
                send_ps2(SC_DIGIT_MAIN[5], 1'b1, KEY_CODE_5);
                send_ps2(SC_DIGIT_PAD[8], 1'b1, KEY_CODE_5);
                send_ps2(SC_DIGIT_MAIN[5], 1'b0, KEY_CODE_8);
                // Shift adds star, digit 8 still outranks it
                send_ps2(SC_SHIFT_L, 1'b1, KEY_CODE_8);
                send_ps2(SC_DIGIT_PAD[8], 1'b0, KEY_CODE_NONE);
                send_ps2(SC_SHIFT_L, 1'b0, KEY_CODE_NONE);
                send_ps2(SC_KP_STAR, 1'b1, KEY_CODE_STAR);
                send_ps2(SC_KP_MINUS, 1'b1, KEY_CODE_STAR);
                send_ps2(SC_KP_STAR, 1'b0, KEY_CODE_HASH);
                send_ps2(SC_KP_MINUS, 1'b0, KEY_CODE_NONE);
                finish_test();

                start_test("reset request");
                @(negedge clk_sys);
                check_bit("sys_rst_n_o before mode change", 1'b1, sys_rst_n);
                console_mode = ~console_mode;
                low_cnt      = 0;
                for (int i = 0; i < 6; i++) begin
                        @(negedge clk_sys);
                        if (i == 0) begin
                                check_bit("sys_rst_n_o after mode change", 1'b0, sys_rst_n);
                        end
                        low_cnt += int'(!sys_rst_n);
                end
                check_int("low cycles after mode change", 1, low_cnt);
                osd_reset = 1'b1;
                for (int i = 0; i < 8; i++) begin
                        @(negedge clk_sys);
                        check_bit("sys_rst_n_o with osd_reset_i held", 1'b0, sys_rst_n);
                end
                osd_reset = 1'b0;
                @(negedge clk_sys);
                check_bit("sys_rst_n_o after osd_reset_i release", 1'b1, sys_rst_n);
                user_button = 1'b1;
                @(negedge clk_sys);
                check_bit("sys_rst_n_o with user_button_i held", 1'b0, sys_rst_n);
                user_button = 1'b0;
                @(negedge clk_sys);
                check_bit("sys_rst_n_o after user_button_i release", 1'b1, sys_rst_n);
                finish_test();

                $display("Summary: %0d tests run, %0d failed, %0d mismatches",
                         tests_run, tests_failed, total_errs);
                if (total_errs == 0) begin
                        $display("Test passed");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule

// File: verif/tb_clk_gen.sv
/*
 * Testbench clock and reset source
 * 40 ns clock, reset held low for the first 10 cycles
 */
`timescale 1ns/1ps

module tb_clk_gen (
        output logic clk_sys,
        output logic rst_n_o
);
        localparam int PERIOD_NS    = 40;
        localparam int RESET_CYCLES = 10;

        initial begin
                clk_sys = 1'b0;
                rst_n_o = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk_sys);
                // Release on a falling edge, clear of the sampling edge
                @(negedge clk_sys);
                rst_n_o = 1'b1;
        end

        always #(PERIOD_NS / 2) clk_sys = ~clk_sys;

endmodule
